/* Makefile */
VERILATOR  ?= verilator
TOP        := routerOutputPort_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
SIM_EXE    := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(SIM_EXE)

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
src/nocPkg.sv
src/holdTimer.sv
src/outputArbiter.sv
src/outputStage.sv
src/routerOutputPort.sv
verification/routerOutputPort_checker.sv
verification/routerOutputPort_tb.sv

/* src/holdTimer.sv */
module holdTimer
  import nocPkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [flitIdWidth-1:0] flitId,
  input  logic [lengthWidth-1:0] length,
  input  logic                   run,
  output logic                   timesUp
);

  logic [lengthWidth-1:0] limit;
  logic [lengthWidth-1:0] count;

  // limit follows every header seen on this input, granted or not.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (flitId == flitHeader)
    begin
      limit <= length;
    end
  end

  // clocks held so far.
  always_ff @(posedge clk)
  begin
    if (rst || !run)
    begin
      count <= '0;
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  // zero limit expires on the first held clock.
  assign timesUp = (count == limit);

endmodule

/* src/nocPkg.sv */
package nocPkg;

  ////////////////////////////////////////
  // port and field sizes
  ////////////////////////////////////////

  // inputs are L, N, E, W, S in index order.
  localparam int numPorts     = 5;
  localparam int flitIdWidth  = 3;
  localparam int lengthWidth  = 12;
  localparam int payloadWidth = 32;
  localparam int portIdxWidth = 3;

  // flit identifier codes.
  localparam logic [flitIdWidth-1:0] flitHeader = 3'd1;
  localparam logic [flitIdWidth-1:0] flitBody   = 3'd2;
  localparam logic [flitIdWidth-1:0] flitTail   = 3'd3;

  ////////////////////////////////////////
  // arbiter state, one-hot
  ////////////////////////////////////////

  localparam int stateWidth = 6;

  localparam logic [stateWidth-1:0] stIdle = 6'b000001;
  localparam logic [stateWidth-1:0] stL    = 6'b000010;
  localparam logic [stateWidth-1:0] stN    = 6'b000100;
  localparam logic [stateWidth-1:0] stE    = 6'b001000;
  localparam logic [stateWidth-1:0] stW    = 6'b010000;
  localparam logic [stateWidth-1:0] stS    = 6'b100000;

endpackage

/* src/outputArbiter.sv */
module outputArbiter
  import nocPkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [numPorts-1:0]                    req,
  input  logic [numPorts-1:0][flitIdWidth-1:0]   flitId,
  input  logic [numPorts-1:0][lengthWidth-1:0]   length,
  output logic [numPorts-1:0]                    grant
);

  logic [stateWidth-1:0] state;
  logic [stateWidth-1:0] nextState;
  logic [numPorts-1:0]   run;
  logic [numPorts-1:0]   timesUp;

  ////////////////////////////////////////
  // hold timers, one per input
  ////////////////////////////////////////

  for (genvar p = 0; p < numPorts; p++)
  begin : gTimer
    holdTimer uTimer (
      .clk     (clk),
      .rst     (rst),
      .flitId  (flitId[p]),
      .length  (length[p]),
      .run     (run[p]),
      .timesUp (timesUp[p])
    );
  end

  ////////////////////////////////////////
  // state register
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= stIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  ////////////////////////////////////////
  // next state and timer run levels
  ////////////////////////////////////////

  always_comb
  begin
    int holder;
    int idx;

    holder    = -1;
    idx       = 0;
    nextState = stIdle;
    run       = '0;

    // current holder index.
    case (state)
      stL:     holder = 0;
      stN:     holder = 1;
      stE:     holder = 2;
      stW:     holder = 3;
      stS:     holder = 4;
      default: holder = -1;
    endcase

    if (state == stIdle)
    begin
      // fixed priority, L wins.
      for (int k = numPorts - 1; k >= 0; k--)
      begin
        if (req[k])
        begin
          nextState = stateWidth'(1) << (k + 1);
        end
      end
    end
    else if (holder >= 0)
    begin
      if (req[holder] && !timesUp[holder])
      begin
        run[holder] = 1'b1;
        nextState   = state;
      end
      else
      begin
        // rotate from holder+1; smallest offset is assigned last and wins.
        // the holder itself is never a candidate here.
        for (int off = numPorts - 1; off >= 1; off--)
        begin
          idx = (holder + off) % numPorts;
          if (req[idx])
          begin
            nextState = stateWidth'(1) << (idx + 1);
          end
        end
      end
    end
    // anything not one-hot falls back to idle.
  end

  assign grant = state[stateWidth-1:1];

endmodule

/* src/outputStage.sv */
module outputStage
  import nocPkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [numPorts-1:0]                    req,
  input  logic [numPorts-1:0]                    grant,
  input  logic [numPorts-1:0][flitIdWidth-1:0]   flitId,
  input  logic [numPorts-1:0][lengthWidth-1:0]   length,
  input  logic [numPorts-1:0][payloadWidth-1:0]  payload,
  output logic                                   outValid,
  output logic [portIdxWidth-1:0]                outSrc,
  output logic [flitIdWidth-1:0]                 outFlitId,
  output logic [lengthWidth-1:0]                 outLength,
  output logic [payloadWidth-1:0]                outPayload
);

  logic [portIdxWidth-1:0] grantIdx;
  logic                    hit;

  // one-hot grant to index.
  always_comb
  begin
    grantIdx = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      if (grant[i])
      begin
        grantIdx = portIdxWidth'(i);
      end
    end
  end

  // granted input must still be requesting.
  assign hit = |(grant & req);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= hit;
    end
  end

  // flit fields hold between forwarded flits.
  always_ff @(posedge clk)
  begin
    if (hit)
    begin
      outSrc     <= grantIdx;
      outFlitId  <= flitId[grantIdx];
      outLength  <= length[grantIdx];
      outPayload <= payload[grantIdx];
    end
  end

endmodule

/* src/routerOutputPort.sv */
module routerOutputPort
  import nocPkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [numPorts-1:0]                    req,
  input  logic [numPorts-1:0][flitIdWidth-1:0]   flitId,
  input  logic [numPorts-1:0][lengthWidth-1:0]   length,
  input  logic [numPorts-1:0][payloadWidth-1:0]  payload,
  output logic [numPorts-1:0]                    grant,
  output logic                                   outValid,
  output logic [portIdxWidth-1:0]                outSrc,
  output logic [flitIdWidth-1:0]                 outFlitId,
  output logic [lengthWidth-1:0]                 outLength,
  output logic [payloadWidth-1:0]                outPayload
);

  ////////////////////////////////////////
  // grant selection
  ////////////////////////////////////////

  outputArbiter uArb (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .flitId (flitId),
    .length (length),
    .grant  (grant)
  );

  ////////////////////////////////////////
  // flit forwarding, one clock behind grant
  ////////////////////////////////////////

  outputStage uStage (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .grant      (grant),
    .flitId     (flitId),
    .length     (length),
    .payload    (payload),
    .outValid   (outValid),
    .outSrc     (outSrc),
    .outFlitId  (outFlitId),
    .outLength  (outLength),
    .outPayload (outPayload)
  );

endmodule

/* verification/routerOutputPort_checker.sv */
module routerOutputPort_checker
  import nocPkg::*;
(
  input logic                  clk,
  input logic                  rst,
  input logic [numPorts-1:0]   req,
  input logic [numPorts-1:0]   grant,
  input logic [stateWidth-1:0] state
);

  timeunit 1ns;
  timeprecision 1ps;

  // assertion failures so far.
  int failCount = 0;

  ////////////////////////////////////////
  // arbiter state properties
  ////////////////////////////////////////

  // exactly one of idle, L, N, E, W, S.
  stateOneHot: assert property (
    @(posedge clk) disable iff (rst) $onehot(state)
  ) else
  begin
    failCount++;
    $error("arbiter state is not one-hot");
  end

  // after the first reset clock the state sits in idle.
  grantClearInReset: assert property (
    @(posedge clk) (rst && $past(rst)) |-> (grant == '0)
  ) else
  begin
    failCount++;
    $error("grant is set while reset is held");
  end

  // a new grant must go to an input that requested one clock earlier.
  grantFollowsReq: assert property (
    @(posedge clk) disable iff (rst)
      ((grant != $past(grant)) && (grant != '0)) |-> ((grant & $past(req)) != '0)
  ) else
  begin
    failCount++;
    $error("grant moved to an input that was not requesting");
  end

endmodule

bind outputArbiter routerOutputPort_checker uChk (
  .clk   (clk),
  .rst   (rst),
  .req   (req),
  .grant (grant),
  .state (state)
);

/* verification/routerOutputPort_tb.sv */
module routerOutputPort_tb
  import nocPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clkPeriod   = 40;
  localparam int resetCycles = 10;
  localparam int numCycles   = 3000;
  localparam int watchdogNs  = (resetCycles + numCycles + 100) * clkPeriod;

  typedef struct packed {
    logic [stateWidth-1:0]                 state;
    logic [numPorts-1:0][lengthWidth-1:0]  limit;
    logic [numPorts-1:0][lengthWidth-1:0]  count;
    logic                                  valid;
    logic [portIdxWidth-1:0]               src;
    logic [flitIdWidth-1:0]                id;
    logic [lengthWidth-1:0]                len;
    logic [payloadWidth-1:0]               data;
  } refModel;

  logic                                  clk = 1'b0;
  logic                                  rst;
  logic [numPorts-1:0]                   req;
  logic [numPorts-1:0][flitIdWidth-1:0]  flitId;
  logic [numPorts-1:0][lengthWidth-1:0]  length;
  logic [numPorts-1:0][payloadWidth-1:0] payload;
  logic [numPorts-1:0]                   grant;
  logic                                  outValid;
  logic [portIdxWidth-1:0]               outSrc;
  logic [flitIdWidth-1:0]                outFlitId;
  logic [lengthWidth-1:0]                outLength;
  logic [payloadWidth-1:0]               outPayload;

  refModel                model;
  logic [15:0]            lfsr;
  int                     budget[numPorts];
  int                     gap[numPorts];
  int                     flitIdx[numPorts];
  int                     flitCount[numPorts];
  logic [lengthWidth-1:0] hdrLen[numPorts];

  routerOutputPort u_dut (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .flitId     (flitId),
    .length     (length),
    .payload    (payload),
    .grant      (grant),
    .outValid   (outValid),
    .outSrc     (outSrc),
    .outFlitId  (outFlitId),
    .outLength  (outLength),
    .outPayload (outPayload)
  );

  initial
  begin
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // random bits and reference model
  ////////////////////////////////////////

  // 16-bit galois lfsr, taps 16 14 13 11.
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      lfsr = lfsrStep(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // one clock of arbiter, hold timers and output register.
  function automatic refModel refStep(
    input refModel                               cur,
    input logic [numPorts-1:0]                   r,
    input logic [numPorts-1:0][flitIdWidth-1:0]  id,
    input logic [numPorts-1:0][lengthWidth-1:0]  len,
    input logic [numPorts-1:0][payloadWidth-1:0] data
  );
    refModel nxt;
    int      holder;
    int      cand;
    nxt    = cur;
    holder = -1;
    for (int p = 0; p < numPorts; p++)
    begin
      if (cur.state[p + 1])
        holder = p;
    end
    nxt.valid = 1'b0;
    if (holder >= 0 && r[holder])
    begin
      nxt.valid = 1'b1;
      nxt.src   = portIdxWidth'(holder);
      nxt.id    = id[holder];
      nxt.len   = len[holder];
      nxt.data  = data[holder];
    end
    for (int p = 0; p < numPorts; p++)
    begin
      if (id[p] == flitHeader)
        nxt.limit[p] = len[p];
    end
    nxt.count = '0;
    nxt.state = stIdle;
    if (holder < 0)
    begin
      for (int p = 0; p < numPorts && nxt.state == stIdle; p++)
      begin
        if (r[p])
          nxt.state = stIdle << (p + 1);
      end
    end
    else if (r[holder] && cur.count[holder] != cur.limit[holder])
    begin
      nxt.state         = cur.state;
      nxt.count[holder] = cur.count[holder] + 1'b1;
    end
    else
    begin
      for (int off = 1; off < numPorts; off++)
      begin
        cand = (holder + off) % numPorts;
        if (r[cand] && nxt.state == stIdle)
          nxt.state = stIdle << (cand + 1);
      end
    end
    return nxt;
  endfunction

  task automatic compareValue(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////
  // compare on the falling edge
  ////////////////////////////////////////

  always @(negedge clk)
  begin
    compareValue("grant", 64'(grant), 64'(model.state[stateWidth-1:1]));
    compareValue("outValid", 64'(outValid), 64'(model.valid));
    if (model.valid)
    begin
      compareValue("outSrc", 64'(outSrc), 64'(model.src));
      compareValue("outFlitId", 64'(outFlitId), 64'(model.id));
      compareValue("outLength", 64'(outLength), 64'(model.len));
      compareValue("outPayload", 64'(outPayload), 64'(model.data));
    end
    if (rst)
    begin
      model       = '0;
      model.state = stIdle;
    end
    else
    begin
      model = refStep(model, req, flitId, length, payload);
    end
  end

  initial
  begin
    #(watchdogNs);
    $display("timeout: the run did not finish within %0d ns", watchdogNs);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // packet drivers, one per input
  ////////////////////////////////////////

  initial
  begin
    logic refresh;
    lfsr        = 16'd88;
    model       = '0;
    model.state = stIdle;
    rst         = 1'b1;
    req         = '0;
    flitId      = '0;
    length      = '0;
    payload     = '0;
    for (int p = 0; p < numPorts; p++)
    begin
      budget[p]    = 0;
      gap[p]       = 0;
      flitIdx[p]   = 0;
      flitCount[p] = 0;
      hdrLen[p]    = '0;
    end
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;

    // all ports start on the same clock, so idle priority is hit first.
    for (int cyc = 0; cyc < numCycles; cyc++)
    begin
      @(posedge clk);
      for (int p = 0; p < numPorts; p++)
      begin
        refresh = 1'b0;
        if (budget[p] > 0)
        begin
          // forwarded flit, move on.
          if (grant[p] && req[p])
          begin
            flitIdx[p]++;
            refresh = 1'b1;
          end
          budget[p]--;
          if (budget[p] == 0)
          begin
            req[p]    <= 1'b0;
            flitId[p] <= '0;
            gap[p]    = int'(randBits(2));
            refresh   = 1'b0;
          end
        end
        else if (gap[p] > 0)
        begin
          gap[p]--;
        end
        else
        begin
          flitCount[p] = 2 + int'(randBits(3));
          budget[p]    = flitCount[p];
          hdrLen[p]    = lengthWidth'(randBits(3));
          flitIdx[p]   = 0;
          req[p]      <= 1'b1;
          refresh      = 1'b1;
        end
        if (refresh)
        begin
          if (flitIdx[p] == 0)
          begin
            flitId[p] <= flitHeader;
            length[p] <= hdrLen[p];
          end
          else
          begin
            // random length on body and tail flits, ignored by the timer.
            flitId[p] <= (flitIdx[p] == flitCount[p] - 1) ? flitTail : flitBody;
            length[p] <= lengthWidth'(randBits(12));
          end
          payload[p] <= randBits(32);
        end
      end
    end

    @(negedge clk);
    #1;
    if (u_dut.uArb.uChk.failCount == 0)
    begin
      $display("Simulation PASSED");
      $finish;
    end
    else
    begin
      $display("Simulation FAILED");
      $fatal(1, "%0d assertions failed", u_dut.uArb.uChk.failCount);
    end
  end

endmodule
